// File: source/gpio_bridge_pkg.sv
////////////////////
// shared sizes, AHB codes, GPIO register map
// and the request/response payload structs
////////////////////

`default_nettype none

package gpio_bridge_pkg;

  // bus widths
  localparam int HADDR_SIZE  = 32;
  localparam int HDATA_SIZE  = 32;
  localparam int PADDR_SIZE  = 10;
  localparam int PDATA_SIZE  = 8;
  localparam int SYNC_STAGES = 3;   // flops per synchronizer

  // HTRANS
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // HSIZE, word is the largest supported
  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // GPIO register map, one byte each
  localparam logic [PADDR_SIZE-1:0] REG_DOUT    = 'd0;
  localparam logic [PADDR_SIZE-1:0] REG_DIR     = 'd1;
  localparam logic [PADDR_SIZE-1:0] REG_DIN     = 'd2;  // read only
  localparam logic [PADDR_SIZE-1:0] REG_SCRATCH = 'd3;
  localparam logic [PADDR_SIZE-1:0] REG_COUNT   = 'd4;  // first bad address

  // HCLK -> PCLK
  typedef struct packed {
    logic [PADDR_SIZE-1:0] addr;
    logic                  write;
    logic [2:0]            size;
    logic [HDATA_SIZE-1:0] wdata;
  } apb_req_t;

  // PCLK -> HCLK
  typedef struct packed {
    logic [HDATA_SIZE-1:0] rdata;
    logic                  err;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: source/ahb_slave_front.sv
////////////////////
// AHB-Lite slave front end, turns one transfer
// into one request and waits for its response
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ahb_slave_front
  import gpio_bridge_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSEL,
  input  logic [HADDR_SIZE-1:0] HADDR,
  input  logic                  HWRITE,
  input  logic [2:0]            HSIZE,
  input  logic [1:0]            HTRANS,
  input  logic                  HREADY,
  input  logic [HDATA_SIZE-1:0] HWDATA,
  output logic [HDATA_SIZE-1:0] HRDATA,
  output logic                  HREADYOUT,
  output logic                  HRESP,
  input  logic                  busy,         // request channel still in round trip
  output logic                  req_valid,
  output apb_req_t              req_payload,
  input  logic                  rsp_valid,
  input  apb_rsp_t              rsp_payload
);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ERR} state_t;

  state_t state;
  logic   accept;     // address phase taken this cycle
  logic   dphase;     // data phase of the taken transfer
  logic   req_pend;   // request held back by busy

  ////////////////////
  // address phase decode
  ////////////////////
  always_comb begin
    accept = 1'b0;
    if (HSEL && HREADY && state == ST_IDLE) begin
      case (HTRANS)
        HTRANS_NONSEQ, HTRANS_SEQ: accept = 1'b1;
        HTRANS_IDLE, HTRANS_BUSY:  accept = 1'b0;   // no transfer
      endcase
    end
  end

  ////////////////////
  // control FSM
  ////////////////////
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= ST_IDLE;
      HREADYOUT <= 1'b1;
      HRESP     <= HRESP_OKAY;
      dphase    <= 1'b0;
      req_pend  <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      req_valid <= 1'b0;   // strobe
      dphase    <= 1'b0;
      case (state)
        ST_IDLE: begin
          HRESP <= HRESP_OKAY;   // ends 2nd error cycle too
          if (accept) begin
            state     <= ST_WAIT;
            HREADYOUT <= 1'b0;   // hold off master
            dphase    <= 1'b1;
          end
        end
        ST_WAIT: begin
          // launch once HWDATA is in and the channel is free
          if (dphase || req_pend) begin
            req_valid <= !busy;
            req_pend  <= busy;
          end
          if (rsp_valid) begin
            if (rsp_payload.err) begin
              HRESP <= HRESP_ERROR;   // first error cycle, HREADYOUT still low
              state <= ST_ERR;
            end else begin
              HREADYOUT <= 1'b1;
              state     <= ST_IDLE;
            end
          end
        end
        ST_ERR: begin
          HREADYOUT <= 1'b1;   // second error cycle
          state     <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // transfer attributes and data, no reset needed
  always_ff @(posedge HCLK) begin
    if (accept) begin
      req_payload.addr  <= HADDR[PADDR_SIZE-1:0];   // HSEL already decodes the window
      req_payload.write <= HWRITE;
      req_payload.size  <= HSIZE;
    end
    if (dphase) req_payload.wdata <= HWDATA;   // data phase
    if (state == ST_WAIT && rsp_valid) HRDATA <= rsp_payload.rdata;
  end

endmodule

`default_nettype wire

// File: source/cdc_handshake_channel.sv
////////////////////
// four-phase req/ack clock crossing,
// payload of any packed type
////////////////////

`timescale 1ns/1ps
`default_nettype none

module cdc_handshake_channel
  import gpio_bridge_pkg::*;
#(
  parameter type payload_t = logic [7:0]
) (
  input  logic     src_clk,
  input  logic     src_rst_n,
  input  logic     src_valid,   // one cycle load strobe
  input  payload_t src_data,
  output logic     busy,
  input  logic     dst_clk,
  input  logic     dst_rst_n,
  output logic     dst_valid,   // one strobe per transfer
  output payload_t dst_data
);

  logic                   req;
  logic                   ack;
  logic                   pend;       // load waiting for the ack to fall
  logic                   launch;
  logic [SYNC_STAGES-1:0] ack_sync;   // dst -> src
  logic [SYNC_STAGES-1:0] req_sync;   // src -> dst
  payload_t               hold;

  ////////////////////
  // source side
  ////////////////////
  // a load during the return half of the round trip raises req later
  assign launch = (src_valid | pend) & ~req & ~ack_sync[SYNC_STAGES-1];
  assign busy   = req | pend | ack_sync[SYNC_STAGES-1];

  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      req      <= 1'b0;
      pend     <= 1'b0;
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[SYNC_STAGES-2:0], ack};
      pend     <= (src_valid | pend) & ~launch;
      if (launch) req <= 1'b1;
      else if (ack_sync[SYNC_STAGES-1]) req <= 1'b0;   // phase 3
    end
  end

  // stays stable from req rise until the next load
  always_ff @(posedge src_clk) begin
    if (src_valid) hold <= src_data;
  end

  ////////////////////
  // destination side
  ////////////////////
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      req_sync <= '0;
      ack      <= 1'b0;
    end else begin
      req_sync <= {req_sync[SYNC_STAGES-2:0], req};
      ack      <= req_sync[SYNC_STAGES-1];   // follows req, phases 2 and 4
    end
  end

  assign dst_valid = req_sync[SYNC_STAGES-1] & ~ack;   // req seen, ack not yet up
  assign dst_data  = hold;

endmodule

`default_nettype wire

// File: source/apb_sequencer.sv
////////////////////
// APB master, one request becomes 1, 2 or 4
// byte beats, response assembled per lane
////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_sequencer
  import gpio_bridge_pkg::*;
(
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  logic                  req_valid,
  input  apb_req_t              req_payload,
  output logic                  rsp_valid,
  output apb_rsp_t              rsp_payload,
  output logic                  PSEL,
  output logic                  PENABLE,
  output logic                  PWRITE,
  output logic [PADDR_SIZE-1:0] PADDR,
  output logic [PDATA_SIZE-1:0] PWDATA,
  input  logic [PDATA_SIZE-1:0] PRDATA,
  input  logic                  PREADY,
  input  logic                  PSLVERR
);

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} state_t;

  state_t                state;
  logic [1:0]            beats_left;   // beats after the current one
  logic [HDATA_SIZE-1:0] wdata;
  logic [PADDR_SIZE-1:0] first_addr;
  logic [PADDR_SIZE-1:0] next_addr;
  logic                  start;
  logic                  beat_done;
  logic                  last_beat;

  // byte of a 32-bit word in lane (addr mod 4)
  function automatic logic [PDATA_SIZE-1:0] lane_byte(input logic [HDATA_SIZE-1:0] word,
                                                      input logic [1:0]            lane);
    lane_byte = word[{lane, 3'b000} +: PDATA_SIZE];
  endfunction

  function automatic logic [1:0] extra_beats(input logic [2:0] size);
    case (size)
      HSIZE_BYTE:  extra_beats = 2'd0;
      HSIZE_HWORD: extra_beats = 2'd1;
      HSIZE_WORD:  extra_beats = 2'd3;
      default:     extra_beats = 2'd0;   // larger sizes not supported
    endcase
  endfunction

  // aligned start address
  always_comb begin
    case (req_payload.size)
      HSIZE_HWORD: first_addr = {req_payload.addr[PADDR_SIZE-1:1], 1'b0};
      HSIZE_WORD:  first_addr = {req_payload.addr[PADDR_SIZE-1:2], 2'b00};
      default:     first_addr = req_payload.addr;
    endcase
  end

  assign start     = req_valid && state == ST_IDLE;
  assign beat_done = state == ST_ACCESS && PREADY;
  assign last_beat = PSLVERR || beats_left == 2'd0;   // stop at first error
  assign next_addr = PADDR + 1'b1;

  ////////////////////
  // beat FSM
  ////////////////////
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      state      <= ST_IDLE;
      PSEL       <= 1'b0;
      PENABLE    <= 1'b0;
      PWRITE     <= 1'b0;
      PADDR      <= '0;
      beats_left <= '0;
      rsp_valid  <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;   // strobe
      case (state)
        ST_IDLE: begin
          if (start) begin
            state      <= ST_SETUP;
            PSEL       <= 1'b1;
            PWRITE     <= req_payload.write;
            PADDR      <= first_addr;
            beats_left <= extra_beats(req_payload.size);
          end
        end
        ST_SETUP: begin
          state   <= ST_ACCESS;
          PENABLE <= 1'b1;
        end
        ST_ACCESS: begin
          if (PREADY) begin
            PENABLE <= 1'b0;
            if (last_beat) begin
              state     <= ST_IDLE;
              PSEL      <= 1'b0;
              rsp_valid <= 1'b1;
            end else begin
              state      <= ST_SETUP;   // back to back beat
              PADDR      <= next_addr;
              beats_left <= beats_left - 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // data lanes
  ////////////////////
  always_ff @(posedge PCLK) begin
    if (start) begin
      wdata       <= req_payload.wdata;
      PWDATA      <= lane_byte(req_payload.wdata, first_addr[1:0]);
      rsp_payload <= '0;   // unread lanes read as 0
    end
    if (beat_done) begin
      if (!PWRITE && !PSLVERR) rsp_payload.rdata[{PADDR[1:0], 3'b000} +: PDATA_SIZE] <= PRDATA;
      if (!last_beat) PWDATA <= lane_byte(wdata, next_addr[1:0]);
      rsp_payload.err <= PSLVERR;
    end
  end

endmodule

`default_nettype wire

// File: source/apb_gpio.sv
////////////////////
// APB GPIO, four byte registers
////////////////////

`timescale 1ns/1ps
`default_nettype none

module apb_gpio
  import gpio_bridge_pkg::*;
(
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  logic                  PSEL,
  input  logic                  PENABLE,
  input  logic                  PWRITE,
  input  logic [PADDR_SIZE-1:0] PADDR,
  input  logic [PDATA_SIZE-1:0] PWDATA,
  output logic [PDATA_SIZE-1:0] PRDATA,
  output logic                  PREADY,
  output logic                  PSLVERR,
  input  logic [PDATA_SIZE-1:0] gpio_in,
  output logic [PDATA_SIZE-1:0] gpio_out,
  output logic [PDATA_SIZE-1:0] gpio_oe
);

  logic [PDATA_SIZE-1:0]                  dout;
  logic [PDATA_SIZE-1:0]                  dir;
  logic [PDATA_SIZE-1:0]                  scratch;
  logic [SYNC_STAGES-1:0][PDATA_SIZE-1:0] pin_sync;
  logic                                   rd_wait;   // read wait state taken
  logic                                   addr_bad;
  logic                                   wr_en;

  assign addr_bad = PADDR >= REG_COUNT;
  assign PREADY   = PSEL & PENABLE & (PWRITE | rd_wait);   // reads one cycle later
  assign PSLVERR  = PREADY & addr_bad;
  assign wr_en    = PREADY & PWRITE & ~addr_bad;           // bad address writes nothing

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      dout     <= '0;
      dir      <= '0;
      scratch  <= '0;
      pin_sync <= '0;
      rd_wait  <= 1'b0;
    end else begin
      pin_sync <= {pin_sync[SYNC_STAGES-2:0], gpio_in};   // async pins
      rd_wait  <= PSEL & PENABLE & ~PWRITE & ~rd_wait;
      if (wr_en) begin
        case (PADDR)
          REG_DOUT:    dout    <= PWDATA;
          REG_DIR:     dir     <= PWDATA;
          REG_SCRATCH: scratch <= PWDATA;
          default:     ;                  // DIN is read only
        endcase
      end
    end
  end

  // read data, sampled in the wait state
  always_ff @(posedge PCLK) begin
    if (PSEL && PENABLE && !PWRITE && !rd_wait) begin
      case (PADDR)
        REG_DOUT:    PRDATA <= dout;
        REG_DIR:     PRDATA <= dir;
        REG_DIN:     PRDATA <= pin_sync[SYNC_STAGES-1];
        REG_SCRATCH: PRDATA <= scratch;
        default:     PRDATA <= '0;
      endcase
    end
  end

  assign gpio_out = dout;
  assign gpio_oe  = dir;

endmodule

`default_nettype wire

// File: source/ahb_gpio_top.sv
////////////////////
// AHB to APB GPIO bridge, two clock domains
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ahb_gpio_top
  import gpio_bridge_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  logic                  HSEL,
  input  logic [HADDR_SIZE-1:0] HADDR,
  input  logic                  HWRITE,
  input  logic [2:0]            HSIZE,
  input  logic [1:0]            HTRANS,
  input  logic                  HREADY,
  input  logic [HDATA_SIZE-1:0] HWDATA,
  output logic [HDATA_SIZE-1:0] HRDATA,
  output logic                  HREADYOUT,
  output logic                  HRESP,
  input  logic [PDATA_SIZE-1:0] gpio_in,
  output logic [PDATA_SIZE-1:0] gpio_out,
  output logic [PDATA_SIZE-1:0] gpio_oe
);

  ////////////////////
  // HCLK domain
  ////////////////////
  logic     req_valid;
  logic     req_busy;
  apb_req_t req_payload;
  logic     hrsp_valid;
  apb_rsp_t hrsp_payload;

  ////////////////////
  // PCLK domain
  ////////////////////
  logic                  preq_valid;
  apb_req_t              preq_payload;
  logic                  prsp_valid;
  apb_rsp_t              prsp_payload;
  logic                  PSEL;
  logic                  PENABLE;
  logic                  PWRITE;
  logic [PADDR_SIZE-1:0] PADDR;
  logic [PDATA_SIZE-1:0] PWDATA;
  logic [PDATA_SIZE-1:0] PRDATA;
  logic                  PREADY;
  logic                  PSLVERR;

  ahb_slave_front u_front (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .HSEL        (HSEL),
    .HADDR       (HADDR),
    .HWRITE      (HWRITE),
    .HSIZE       (HSIZE),
    .HTRANS      (HTRANS),
    .HREADY      (HREADY),
    .HWDATA      (HWDATA),
    .HRDATA      (HRDATA),
    .HREADYOUT   (HREADYOUT),
    .HRESP       (HRESP),
    .busy        (req_busy),
    .req_valid   (req_valid),
    .req_payload (req_payload),
    .rsp_valid   (hrsp_valid),
    .rsp_payload (hrsp_payload)
  );

  // HCLK -> PCLK
  cdc_handshake_channel #(.payload_t(apb_req_t)) u_req_chan (
    .src_clk   (HCLK),
    .src_rst_n (HRESETn),
    .src_valid (req_valid),
    .src_data  (req_payload),
    .busy      (req_busy),
    .dst_clk   (PCLK),
    .dst_rst_n (PRESETn),
    .dst_valid (preq_valid),
    .dst_data  (preq_payload)
  );

  // PCLK -> HCLK, a late response waits inside the channel
  cdc_handshake_channel #(.payload_t(apb_rsp_t)) u_rsp_chan (
    .src_clk   (PCLK),
    .src_rst_n (PRESETn),
    .src_valid (prsp_valid),
    .src_data  (prsp_payload),
    .busy      (),
    .dst_clk   (HCLK),
    .dst_rst_n (HRESETn),
    .dst_valid (hrsp_valid),
    .dst_data  (hrsp_payload)
  );

  apb_sequencer u_seq (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .req_valid   (preq_valid),
    .req_payload (preq_payload),
    .rsp_valid   (prsp_valid),
    .rsp_payload (prsp_payload),
    .PSEL        (PSEL),
    .PENABLE     (PENABLE),
    .PWRITE      (PWRITE),
    .PADDR       (PADDR),
    .PWDATA      (PWDATA),
    .PRDATA      (PRDATA),
    .PREADY      (PREADY),
    .PSLVERR     (PSLVERR)
  );

  apb_gpio u_gpio (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PWRITE   (PWRITE),
    .PADDR    (PADDR),
    .PWDATA   (PWDATA),
    .PRDATA   (PRDATA),
    .PREADY   (PREADY),
    .PSLVERR  (PSLVERR),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

endmodule

`default_nettype wire

// File: tests/ahb_gpio_sva.sv
////////////////////
// APB and AHB response protocol assertions bound into the top
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ahb_gpio_sva
  import gpio_bridge_pkg::*;
(
  input wire logic                  HCLK,
  input wire logic                  HRESETn,
  input wire logic                  PCLK,
  input wire logic                  PRESETn,
  input wire logic                  HREADYOUT,
  input wire logic                  HRESP,
  input wire logic                  PSEL,
  input wire logic                  PENABLE,
  input wire logic                  PWRITE,
  input wire logic [PADDR_SIZE-1:0] PADDR,
  input wire logic                  PREADY
);

  int fails = 0;   // assertion failures so far

  // access phase only inside a selected transfer
  a_enable_sel: assert property (@(posedge PCLK) disable iff (!PRESETn)
    PENABLE |-> PSEL)
    else begin
      $error("PENABLE high without PSEL");
      fails++;
    end

  // setup and waited access cycles keep the beat attributes
  a_apb_stable: assert property (@(posedge PCLK) disable iff (!PRESETn)
    (PSEL && !(PENABLE && PREADY)) |=> ($stable(PADDR) && $stable(PWRITE)))
    else begin
      $error("PADDR or PWRITE changed before PREADY");
      fails++;
    end

  // ERROR with low HREADYOUT then high then back to OKAY
  a_two_cycle_err: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(HRESP) |-> !HREADYOUT ##1 (HRESP && HREADYOUT) ##1 !HRESP)
    else begin
      $error("ERROR response not two cycles");
      fails++;
    end

endmodule

bind ahb_gpio_top ahb_gpio_sva u_sva (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .PCLK      (PCLK),
  .PRESETn   (PRESETn),
  .HREADYOUT (HREADYOUT),
  .HRESP     (HRESP),
  .PSEL      (PSEL),
  .PENABLE   (PENABLE),
  .PWRITE    (PWRITE),
  .PADDR     (PADDR),
  .PREADY    (PREADY)
);

`default_nettype wire

// File: tests/ahb_gpio_tb.sv
////////////////////
// clocks, AHB driver, reference register model
// and the process that compares each completed transfer
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ahb_gpio_tb
  import gpio_bridge_pkg::*;
();

  localparam int XFER_TIMEOUT  = 400;   // HCLK cycles per transfer
  localparam int DRAIN_TIMEOUT = 50;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  PCLK;
  logic                  PRESETn;
  logic                  HSEL;
  logic [HADDR_SIZE-1:0] HADDR;
  logic                  HWRITE;
  logic [2:0]            HSIZE;
  logic [1:0]            HTRANS;
  logic                  HREADY;
  logic [HDATA_SIZE-1:0] HWDATA;
  logic [HDATA_SIZE-1:0] HRDATA;
  logic                  HREADYOUT;
  logic                  HRESP;
  logic [PDATA_SIZE-1:0] gpio_in;
  logic [PDATA_SIZE-1:0] gpio_out;
  logic [PDATA_SIZE-1:0] gpio_oe;

  logic [7:0]  model [0:3];   // DOUT, DIR, DIN (unused), SCRATCH
  logic [33:0] exp_q [$];     // {is_read, err, rdata}
  logic [31:0] lcg_state;
  logic        data_active;   // data phase in flight on the bus
  logic        prev_err_wait; // last cycle was the first ERROR cycle

  ahb_gpio_top UUT (.*);

  always #20 HCLK = ~HCLK;    // 40 ns
  always #50 PCLK = ~PCLK;    // 100 ns period unrelated to HCLK

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int beat_count(input logic [2:0] size);
    if (size == HSIZE_WORD) return 4;
    if (size == HSIZE_HWORD) return 2;
    return 1;
  endfunction

  // expected {err, rdata} with the byte at address a in lane a mod 4
  function automatic logic [32:0] ref_result(input logic [PADDR_SIZE-1:0] addr,
                                             input logic [2:0]            size,
                                             input logic [7:0]            pins);
    logic [31:0]           data;
    logic                  err;
    logic [PADDR_SIZE-1:0] a;
    int                    beats;
    data  = '0;
    err   = 1'b0;
    beats = beat_count(size);
    for (int i = 0; i < beats; i++) begin
      a = addr - (addr % beats) + i;
      if (!err) begin
        if (a >= REG_COUNT) err = 1'b1;   // stops at first bad beat
        else if (a == REG_DIN) data[8*a[1:0] +: 8] = pins;
        else data[8*a[1:0] +: 8] = model[a[1:0]];
      end
    end
    return {err, data};
  endfunction

  task automatic apply_write(input logic [PADDR_SIZE-1:0] addr, input logic [2:0] size,
                             input logic [31:0] wdata);
    logic [PADDR_SIZE-1:0] a;
    logic                  stop;
    int                    beats;
    stop  = 1'b0;
    beats = beat_count(size);
    for (int i = 0; i < beats; i++) begin
      a = addr - (addr % beats) + i;
      if (a >= REG_COUNT) stop = 1'b1;
      if (!stop && a != REG_DIN) model[a[1:0]] = wdata[8*a[1:0] +: 8];   // DIN read only
    end
  endtask

  ////////////////////
  // failure reporting
  ////////////////////
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, want);
    $display("Something failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_problem(input string what);
    $display("%s at %0t ns", what, $time);
    $display("Something failed");
    $fatal(1, "stopped at first problem");
  endtask

  ////////////////////
  // AHB driver called 2 ns after a rising HCLK
  ////////////////////
  task automatic ahb_xfer(input logic [PADDR_SIZE-1:0] addr, input logic write,
                          input logic [2:0] size, input logic [31:0] wdata);
    logic [32:0] want;
    int          waited;
    want = ref_result(addr, size, gpio_in);
    exp_q.push_back({!write, want});
    if (write) apply_write(addr, size, wdata);
    HSEL   = 1'b1;                 // address phase
    HADDR  = {{(HADDR_SIZE-PADDR_SIZE){1'b0}}, addr};
    HWRITE = write;
    HSIZE  = size;
    HTRANS = HTRANS_NONSEQ;
    @(posedge HCLK);
    #2;
    HSEL   = 1'b0;                 // data phase
    HTRANS = HTRANS_IDLE;
    HWDATA = wdata;
    waited = 0;
    while (!HREADYOUT && waited < XFER_TIMEOUT) begin
      @(posedge HCLK);
      #2;
      waited++;
    end
    if (!HREADYOUT) begin
      $display("Something failed");
      $fatal(1, "HREADYOUT stayed low for %0d cycles", XFER_TIMEOUT);
    end
  endtask

  // address phase that must be ignored
  task automatic null_phase(input logic sel, input logic [1:0] trans,
                            input logic [PADDR_SIZE-1:0] addr);
    HSEL   = sel;
    HADDR  = {{(HADDR_SIZE-PADDR_SIZE){1'b0}}, addr};
    HWRITE = 1'b1;
    HSIZE  = HSIZE_WORD;
    HTRANS = trans;
    @(posedge HCLK);
    #2;
    HSEL   = 1'b0;
    HTRANS = HTRANS_IDLE;
    HWDATA = 32'hffff_ffff;        // would clobber everything
    repeat (3) begin
      assert (HREADYOUT == 1'b1) else report_mismatch("HREADYOUT", HREADYOUT, 1);
      @(posedge HCLK);
      #2;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge HCLK);
      #2;
    end
  endtask

  task automatic check_pins();
    assert (gpio_out == model[0]) else report_mismatch("gpio_out", gpio_out, model[0]);
    assert (gpio_oe == model[1]) else report_mismatch("gpio_oe", gpio_oe, model[1]);
  endtask

  ////////////////////
  // comparing process
  ////////////////////
  always @(posedge HCLK or negedge HRESETn) begin
    logic [33:0] want;
    if (!HRESETn) begin
      data_active   = 1'b0;
      prev_err_wait = 1'b0;
    end else begin
      if (data_active && HREADYOUT) begin   // transfer ends at this edge
        if (exp_q.size() == 0) report_problem("transfer completed with none expected");
        want = exp_q.pop_front();
        assert (HRESP == want[32]) else report_mismatch("HRESP", HRESP, want[32]);
        if (want[33] && !want[32])
          assert (HRDATA == want[31:0]) else report_mismatch("HRDATA", HRDATA, want[31:0]);
        if (HRESP == HRESP_ERROR)
          assert (prev_err_wait) else report_problem("ERROR response lacked its first cycle");
      end
      if (HREADYOUT) data_active = HSEL && HREADY && HTRANS[1];
      prev_err_wait = (HRESP == HRESP_ERROR) && !HREADYOUT;
    end
  end

  // bound protocol assertions end the run as soon as one fails
  always @(UUT.u_sva.fails) begin
    assert (UUT.u_sva.fails == 0) else report_problem("protocol assertion failed");
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    logic [PADDR_SIZE-1:0] addr;
    logic [2:0]            size;
    logic                  write;
    int                    n;
    HCLK      = 1'b0;
    PCLK      = 1'b0;
    HRESETn   = 1'b0;
    PRESETn   = 1'b0;
    HSEL      = 1'b0;
    HADDR     = '0;
    HWRITE    = 1'b0;
    HSIZE     = HSIZE_BYTE;
    HTRANS    = HTRANS_IDLE;
    HREADY    = 1'b1;      // single slave on the bus
    HWDATA    = '0;
    gpio_in   = '0;
    lcg_state = 32'd35;
    for (int i = 0; i < 4; i++) model[i] = '0;
    repeat (4) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;
    PRESETn = 1'b1;

    // reset values
    assert (HREADYOUT == 1'b1) else report_mismatch("HREADYOUT", HREADYOUT, 1);
    assert (HRESP == HRESP_OKAY) else report_mismatch("HRESP", HRESP, HRESP_OKAY);
    check_pins();
    idle_cycles(4);

    // byte writes in lane addr mod 4
    for (int i = 0; i < 4; i++) begin
      lcg_state = lcg_step(lcg_state);
      if (i != 2) ahb_xfer(i, 1'b1, HSIZE_BYTE, lcg_state);
    end
    check_pins();
    lcg_state = lcg_step(lcg_state);
    gpio_in   = lcg_state[23:16];   // held well past the synchronizer
    idle_cycles(20);
    for (int i = 0; i < 4; i++) ahb_xfer(i, 1'b0, HSIZE_BYTE, '0);

    // word access
    lcg_state = lcg_step(lcg_state);
    ahb_xfer(0, 1'b1, HSIZE_WORD, lcg_state);
    check_pins();
    ahb_xfer(0, 1'b0, HSIZE_WORD, '0);

    // halfword at 2 with lanes 0/1 reading back as 0
    lcg_state = lcg_step(lcg_state);
    ahb_xfer(2, 1'b1, HSIZE_HWORD, lcg_state);
    ahb_xfer(2, 1'b0, HSIZE_HWORD, '0);
    ahb_xfer(0, 1'b0, HSIZE_HWORD, '0);

    // out of range accesses get the two-cycle ERROR
    ahb_xfer(4, 1'b1, HSIZE_WORD, 32'hdead_beef);
    ahb_xfer(5, 1'b0, HSIZE_BYTE, '0);
    ahb_xfer(10'h3fe, 1'b1, HSIZE_HWORD, 32'h5a5a_5a5a);
    ahb_xfer(0, 1'b0, HSIZE_WORD, '0);

    // ignored address phases
    null_phase(1'b1, HTRANS_IDLE, 0);
    null_phase(1'b1, HTRANS_BUSY, 1);
    null_phase(1'b0, HTRANS_NONSEQ, 3);
    check_pins();
    ahb_xfer(0, 1'b0, HSIZE_WORD, '0);

    // back to back random mix with the next phase as soon as HREADYOUT rises
    for (n = 0; n < 12; n++) begin
      lcg_state = lcg_step(lcg_state);
      size      = (lcg_state[17:16] == 2'd3) ? HSIZE_BYTE : {1'b0, lcg_state[17:16]};
      addr      = {7'd0, lcg_state[26:24]};   // 4..7 out of range
      addr      = addr - (addr % beat_count(size));
      write     = lcg_state[28];
      lcg_state = lcg_step(lcg_state);
      ahb_xfer(addr, write, size, lcg_state);
    end
    check_pins();

    // let the last transfers get compared
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(posedge HCLK);
      #2;
      n++;
    end
    if (exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "%0d transfers never completed", exp_q.size());
    end
  end

endmodule

`default_nettype wire

// File: list.f
source/gpio_bridge_pkg.sv
source/ahb_slave_front.sv
source/cdc_handshake_channel.sv
source/apb_sequencer.sv
source/apb_gpio.sv
source/ahb_gpio_top.sv
tests/ahb_gpio_sva.sv
tests/ahb_gpio_tb.sv

// File: Bender.yml
package:
  name: ahb_gpio_bridge

sources:
  - files:
      - source/gpio_bridge_pkg.sv
      - source/ahb_slave_front.sv
      - source/cdc_handshake_channel.sv
      - source/apb_sequencer.sv
      - source/apb_gpio.sv
      - source/ahb_gpio_top.sv
  - target: test
    files:
      - tests/ahb_gpio_sva.sv
      - tests/ahb_gpio_tb.sv
